// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////
// Core sizing
//////////////////////////////

// Datapath and register width
`define XLEN 32

// Word address width of imem and dmem
`define MEM_AW 12

// Architectural registers, r0 reads as zero
`define NREGS 32

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [4:0] reg_idx_t;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	typedef enum logic [4:0] {
		op_rtype = 5'b00000,
		op_j     = 5'b00001,
		op_bne   = 5'b00010,
		op_jal   = 5'b00011,
		op_jr    = 5'b00100,
		op_addi  = 5'b00101,
		op_blt   = 5'b00110,
		op_sw    = 5'b00111,
		op_lw    = 5'b01000
	} opcode_e;

	typedef enum logic [4:0] {
		alu_add = 5'b00000,
		alu_sub = 5'b00001,
		alu_and = 5'b00010,
		alu_or  = 5'b00011,
		alu_sll = 5'b00100,
		alu_sra = 5'b00101
	} alu_op_e;

	// Forwarding source for one operand
	typedef enum logic [1:0] {
		fwd_none,
		fwd_exe,
		fwd_mem,
		fwd_wb
	} fwd_e;

	//////////////////////////////
	// Instruction formats
	//////////////////////////////

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rd;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [4:0] shamt;
		alu_op_e    aluop;
		logic [1:0] spare;
	} instr_r_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rd;
		reg_idx_t    rs;
		logic [16:0] imm;
	} instr_i_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [26:0] target;
	} instr_j_t;

	//////////////////////////////
	// Decoded controls and latches
	//////////////////////////////

	// All-zero value is a bubble with no side effects
	typedef struct packed {
		alu_op_e          alu_op;
		logic [4:0]       shamt;
		logic [`XLEN-1:0] imm;
		logic [26:0]      target;
		reg_idx_t         rd;
		reg_idx_t         rs_a;
		reg_idx_t         rs_b;
		logic             use_imm;
		logic             reg_we;
		logic             is_load;
		logic             is_store;
		logic             is_jal;
		logic             is_jump;
		logic             is_jr;
		logic             is_bne;
		logic             is_blt;
	} ctrl_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc_plus1;
		logic [`XLEN-1:0] instr;
	} fd_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc_plus1;
		ctrl_t            ctrl;
		logic [`XLEN-1:0] op_a;
		logic [`XLEN-1:0] op_b;
	} de_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc_plus1;
		ctrl_t            ctrl;
		logic [`XLEN-1:0] alu_result;
		logic [`XLEN-1:0] store_data;
	} em_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc_plus1;
		ctrl_t            ctrl;
		logic [`XLEN-1:0] alu_result;
		logic [`XLEN-1:0] load_data;
	} mw_t;

endpackage

// File: verilog/stage_latch.sv
`timescale 1ns/100ps

module stage_latch #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     en,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Zero payload doubles as the bubble
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (en) begin
			if (flush)
				q <= '0;
			else
				q <= d;
		end
	end

endmodule

// File: verilog/sync_ram.sv
`timescale 1ns/100ps

module sync_ram #(
	parameter int depth = 4096,
	parameter int width = 32
) (
	input  logic                     clock,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] addr,
	input  logic [width-1:0]         wdata,
	output logic [width-1:0]         rdata
);

	logic [width-1:0] mem [depth];

	// Write on the rising edge
	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wdata;
	end

	// Read is combinational so a stage sees its word in the same cycle
	assign rdata = mem[addr];

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module regfile (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              we,
	input  cpu_pkg::reg_idx_t waddr,
	input  logic [`XLEN-1:0]  wdata,
	input  cpu_pkg::reg_idx_t raddr_a,
	input  cpu_pkg::reg_idx_t raddr_b,
	output logic [`XLEN-1:0]  rdata_a,
	output logic [`XLEN-1:0]  rdata_b
);

	logic [`XLEN-1:0] regs [`NREGS];
	logic             live_we;

	// r0 is never written so it stays at its reset value
	assign live_we = we && (waddr != '0);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (live_we) begin
			regs[waddr] <= wdata;
		end
	end

	// Writeback in the same cycle passes straight through
	assign rdata_a = (live_we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (live_we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// File: verilog/alu.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu (
	input  logic [`XLEN-1:0]         a,
	input  logic [`XLEN-1:0]         b,
	input  cpu_pkg::alu_op_e         op,
	input  logic [$clog2(`XLEN)-1:0] shamt,
	output logic [`XLEN-1:0]         result,
	output logic                     not_equal,
	output logic                     less_than
);

	logic [`XLEN:0] diff;

	// One extra sign bit, so the top bit is the signed a < b
	assign diff      = {a[`XLEN-1], a} - {b[`XLEN-1], b};
	assign not_equal = |diff[`XLEN-1:0];
	assign less_than = diff[`XLEN];

	always_comb begin
		case (op)
			cpu_pkg::alu_add:
				result = a + b;
			cpu_pkg::alu_sub:
				result = diff[`XLEN-1:0];
			cpu_pkg::alu_and:
				result = a & b;
			cpu_pkg::alu_or:
				result = a | b;
			cpu_pkg::alu_sll:
				result = a << shamt;
			cpu_pkg::alu_sra:
				result = $signed(a) >>> shamt;
			default:
				result = '0;
		endcase
	end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decoder (
	input  logic [`XLEN-1:0] instr,
	output cpu_pkg::ctrl_t   ctrl
);

	cpu_pkg::instr_r_t r_fmt;
	cpu_pkg::instr_i_t i_fmt;
	cpu_pkg::instr_j_t j_fmt;

	// Same word seen through each format
	assign r_fmt = instr;
	assign i_fmt = instr;
	assign j_fmt = instr;

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = cpu_pkg::alu_add;
		ctrl.shamt  = r_fmt.shamt;
		ctrl.imm    = {{(`XLEN-17){i_fmt.imm[16]}}, i_fmt.imm};
		ctrl.target = j_fmt.target;
		ctrl.rd     = r_fmt.rd;
		ctrl.rs_a   = r_fmt.rs;
		ctrl.rs_b   = r_fmt.rt;

		case (r_fmt.opcode)
			cpu_pkg::op_rtype: begin
				ctrl.alu_op = r_fmt.aluop;
				ctrl.reg_we = 1'b1;
			end
			cpu_pkg::op_addi: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			cpu_pkg::op_lw: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
				ctrl.is_load = 1'b1;
			end
			// rd is a source here, read and forwarded on port B
			cpu_pkg::op_sw: begin
				ctrl.use_imm  = 1'b1;
				ctrl.is_store = 1'b1;
				ctrl.rs_b     = r_fmt.rd;
			end
			cpu_pkg::op_bne: begin
				ctrl.is_bne = 1'b1;
				ctrl.rs_b   = r_fmt.rd;
			end
			cpu_pkg::op_blt: begin
				ctrl.is_blt = 1'b1;
				ctrl.rs_b   = r_fmt.rd;
			end
			cpu_pkg::op_j: begin
				ctrl.is_jump = 1'b1;
			end
			cpu_pkg::op_jal: begin
				ctrl.is_jump = 1'b1;
				ctrl.is_jal  = 1'b1;
				ctrl.reg_we  = 1'b1;
				ctrl.rd      = 5'd31;
			end
			cpu_pkg::op_jr: begin
				ctrl.is_jump = 1'b1;
				ctrl.is_jr   = 1'b1;
				ctrl.rs_b    = r_fmt.rd;
			end
			default: begin
				ctrl.reg_we = 1'b0;
			end
		endcase

		// Writes to r0 vanish here, nothing downstream sees them
		if (ctrl.rd == '0)
			ctrl.reg_we = 1'b0;
	end

endmodule

// File: verilog/bypass_unit.sv
`timescale 1ns/100ps

module bypass_unit (
	input  cpu_pkg::ctrl_t dec_ctrl,
	input  cpu_pkg::ctrl_t exe_ctrl,
	input  cpu_pkg::ctrl_t mem_ctrl,
	input  cpu_pkg::ctrl_t wb_ctrl,
	output cpu_pkg::fwd_e  dec_sel_a,
	output cpu_pkg::fwd_e  dec_sel_b,
	output cpu_pkg::fwd_e  exe_sel_a,
	output cpu_pkg::fwd_e  exe_sel_b,
	output logic           mem_store_fwd
);

	function automatic logic writes(
		input cpu_pkg::ctrl_t    producer,
		input cpu_pkg::reg_idx_t src
	);
		return producer.reg_we && (producer.rd == src);
	endfunction

	// Youngest producer wins
	function automatic cpu_pkg::fwd_e pick(
		input cpu_pkg::reg_idx_t src,
		input logic              exe_allowed,
		input cpu_pkg::ctrl_t    exe,
		input cpu_pkg::ctrl_t    mem,
		input cpu_pkg::ctrl_t    wb
	);
		// Load data does not exist until the memory stage
		if (exe_allowed && !exe.is_load && writes(exe, src))
			return cpu_pkg::fwd_exe;
		if (writes(mem, src))
			return cpu_pkg::fwd_mem;
		if (writes(wb, src))
			return cpu_pkg::fwd_wb;
		return cpu_pkg::fwd_none;
	endfunction

	// Decode sees execute, memory and writeback
	assign dec_sel_a = pick(dec_ctrl.rs_a, 1'b1, exe_ctrl, mem_ctrl, wb_ctrl);
	assign dec_sel_b = pick(dec_ctrl.rs_b, 1'b1, exe_ctrl, mem_ctrl, wb_ctrl);

	// Execute only has older stages behind it
	assign exe_sel_a = pick(exe_ctrl.rs_a, 1'b0, exe_ctrl, mem_ctrl, wb_ctrl);
	assign exe_sel_b = pick(exe_ctrl.rs_b, 1'b0, exe_ctrl, mem_ctrl, wb_ctrl);

	// Store data patched from writeback
	assign mem_store_fwd = mem_ctrl.is_store && writes(wb_ctrl, mem_ctrl.rs_b);

endmodule

// File: verilog/processor.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module processor (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               run,
	input  logic               prog_we,
	input  logic [`MEM_AW-1:0] prog_addr,
	input  logic [`XLEN-1:0]   prog_data,
	output logic               wb_we,
	output cpu_pkg::reg_idx_t  wb_reg,
	output logic [`XLEN-1:0]   wb_data,
	output logic               debug_we,
	output logic [`MEM_AW-1:0] debug_addr,
	output logic [`XLEN-1:0]   debug_data
);

	cpu_pkg::fd_t   fd_d, fd_q;
	cpu_pkg::de_t   de_d, de_q;
	cpu_pkg::em_t   em_d, em_q;
	cpu_pkg::mw_t   mw_d, mw_q;
	cpu_pkg::ctrl_t dec_ctrl;
	cpu_pkg::fwd_e  dec_sel_a, dec_sel_b, exe_sel_a, exe_sel_b;
	logic           mem_store_fwd;

	logic [`XLEN-1:0]   pc, pc_plus1, pc_next, imem_rdata;
	logic [`MEM_AW-1:0] imem_addr;
	logic [`XLEN-1:0]   rf_a, rf_b, dec_a, dec_b, branch_target;
	logic               dec_ne, dec_lt, branch_taken;
	logic [`XLEN-1:0]   exe_a, exe_b, alu_b, alu_out, exe_result, jump_target;
	logic               jump_taken;
	logic [`XLEN-1:0]   dmem_rdata, mem_result, store_data;

	// What an instruction in a given stage will write back
	function automatic logic [`XLEN-1:0] stage_value(
		input cpu_pkg::ctrl_t   ctrl,
		input logic [`XLEN-1:0] link,
		input logic [`XLEN-1:0] alu_v,
		input logic [`XLEN-1:0] load_v
	);
		if (ctrl.is_jal)
			return link;
		if (ctrl.is_load)
			return load_v;
		return alu_v;
	endfunction

	function automatic logic [`XLEN-1:0] fwd_mux(
		input cpu_pkg::fwd_e    sel,
		input logic [`XLEN-1:0] base,
		input logic [`XLEN-1:0] from_exe,
		input logic [`XLEN-1:0] from_mem,
		input logic [`XLEN-1:0] from_wb
	);
		case (sel)
			cpu_pkg::fwd_exe: return from_exe;
			cpu_pkg::fwd_mem: return from_mem;
			cpu_pkg::fwd_wb:  return from_wb;
			default:          return base;
		endcase
	endfunction

	//////////////////////////////
	// Fetch
	//////////////////////////////

	assign pc_plus1 = pc + 1'b1;

	// Jump is older than the branch and wins
	assign pc_next = jump_taken ? jump_target : (branch_taken ? branch_target : pc_plus1);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (run)
			pc <= pc_next;
	end

	// Program port owns imem while the core is stopped
	assign imem_addr = run ? pc[`MEM_AW-1:0] : prog_addr;
	sync_ram #(.depth(1 << `MEM_AW), .width(`XLEN)) imem (
		.clock(clock), .we(prog_we & ~run), .addr(imem_addr),
		.wdata(prog_data), .rdata(imem_rdata)
	);

	assign fd_d = '{pc_plus1: pc_plus1, instr: imem_rdata};

	// Without hazard stalls every latch advances each cycle
	stage_latch #(.payload_t(cpu_pkg::fd_t)) fd_latch (
		.clock(clock), .rst_n(rst_n), .en(1'b1),
		.flush(jump_taken | branch_taken | ~run), .d(fd_d), .q(fd_q)
	);

	//////////////////////////////
	// Decode and branch compare
	//////////////////////////////

	decoder dec (.instr(fd_q.instr), .ctrl(dec_ctrl));

	regfile rf (
		.clock(clock), .rst_n(rst_n), .we(mw_q.ctrl.reg_we), .waddr(mw_q.ctrl.rd),
		.wdata(wb_data), .raddr_a(dec_ctrl.rs_a), .raddr_b(dec_ctrl.rs_b),
		.rdata_a(rf_a), .rdata_b(rf_b)
	);

	assign dec_a = fwd_mux(dec_sel_a, rf_a, exe_result, mem_result, wb_data);
	assign dec_b = fwd_mux(dec_sel_b, rf_b, exe_result, mem_result, wb_data);

	// Operands swapped so less_than reads as rd < rs
	alu cmp_alu (
		.a(dec_b), .b(dec_a), .op(cpu_pkg::alu_sub), .shamt('0),
		.result(), .not_equal(dec_ne), .less_than(dec_lt)
	);

	assign branch_taken  = (dec_ctrl.is_bne & dec_ne) | (dec_ctrl.is_blt & dec_lt);
	assign branch_target = fd_q.pc_plus1 + dec_ctrl.imm;

	assign de_d = '{pc_plus1: fd_q.pc_plus1, ctrl: dec_ctrl, op_a: dec_a, op_b: dec_b};
	stage_latch #(.payload_t(cpu_pkg::de_t)) de_latch (
		.clock(clock), .rst_n(rst_n), .en(1'b1), .flush(jump_taken), .d(de_d), .q(de_q)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////

	// Only memory and writeback can still supply a newer value here
	assign exe_a = (exe_sel_a == cpu_pkg::fwd_mem) ? mem_result :
		(exe_sel_a == cpu_pkg::fwd_wb) ? wb_data : de_q.op_a;
	assign exe_b = (exe_sel_b == cpu_pkg::fwd_mem) ? mem_result :
		(exe_sel_b == cpu_pkg::fwd_wb) ? wb_data : de_q.op_b;
	assign alu_b = de_q.ctrl.use_imm ? de_q.ctrl.imm : exe_b;

	alu ex_alu (
		.a(exe_a), .b(alu_b), .op(de_q.ctrl.alu_op), .shamt(de_q.ctrl.shamt),
		.result(alu_out), .not_equal(), .less_than()
	);

	// A load in execute is never a forwarding source
	assign exe_result  = de_q.ctrl.is_jal ? de_q.pc_plus1 : alu_out;
	assign jump_taken  = de_q.ctrl.is_jump;
	assign jump_target = de_q.ctrl.is_jr ? exe_b : `XLEN'(de_q.ctrl.target);

	assign em_d = '{pc_plus1: de_q.pc_plus1, ctrl: de_q.ctrl, alu_result: alu_out,
		store_data: exe_b};
	stage_latch #(.payload_t(cpu_pkg::em_t)) em_latch (
		.clock(clock), .rst_n(rst_n), .en(1'b1), .flush(1'b0), .d(em_d), .q(em_q)
	);

	//////////////////////////////
	// Memory and writeback
	//////////////////////////////

	assign store_data = mem_store_fwd ? wb_data : em_q.store_data;

	sync_ram #(.depth(1 << `MEM_AW), .width(`XLEN)) dmem (
		.clock(clock), .we(em_q.ctrl.is_store), .addr(em_q.alu_result[`MEM_AW-1:0]),
		.wdata(store_data), .rdata(dmem_rdata)
	);

	assign mem_result = stage_value(em_q.ctrl, em_q.pc_plus1, em_q.alu_result, dmem_rdata);

	assign mw_d = '{pc_plus1: em_q.pc_plus1, ctrl: em_q.ctrl, alu_result: em_q.alu_result,
		load_data: dmem_rdata};
	stage_latch #(.payload_t(cpu_pkg::mw_t)) mw_latch (
		.clock(clock), .rst_n(rst_n), .en(1'b1), .flush(1'b0), .d(mw_d), .q(mw_q)
	);

	bypass_unit byp (
		.dec_ctrl(dec_ctrl), .exe_ctrl(de_q.ctrl), .mem_ctrl(em_q.ctrl), .wb_ctrl(mw_q.ctrl),
		.dec_sel_a(dec_sel_a), .dec_sel_b(dec_sel_b), .exe_sel_a(exe_sel_a),
		.exe_sel_b(exe_sel_b), .mem_store_fwd(mem_store_fwd)
	);

	// Trace ports
	assign wb_we      = mw_q.ctrl.reg_we;
	assign wb_reg     = mw_q.ctrl.rd;
	assign wb_data    = stage_value(mw_q.ctrl, mw_q.pc_plus1, mw_q.alu_result, mw_q.load_data);
	assign debug_we   = em_q.ctrl.is_store;
	assign debug_addr = em_q.alu_result[`MEM_AW-1:0];
	assign debug_data = store_data;

endmodule

// File: sim/processor_checker.sv
`timescale 1ns/100ps

module processor_checker (
	input logic              clock,
	input logic              rst_n,
	input logic              wb_we,
	input cpu_pkg::reg_idx_t wb_reg,
	input logic              debug_we
);

	// Failures seen so far, read by the testbench at the end
	int fail_count;

	initial fail_count = 0;

	//////////////////////////////
	// Strobes under reset
	//////////////////////////////

	quiet_in_reset: assert property (@(posedge clock) !rst_n |-> (!wb_we && !debug_we))
		else begin
			fail_count++;
			$error("writeback or store strobe high while rst_n is low");
		end

	// r0 writes are dropped in decode
	no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
		wb_we |-> (wb_reg != '0))
		else begin
			fail_count++;
			$error("writeback strobe with register zero as target");
		end

	//////////////////////////////
	// Strobe sanity
	//////////////////////////////

	known_strobes: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(wb_we) && !$isunknown(debug_we))
		else begin
			fail_count++;
			$error("writeback or store strobe unknown after reset");
		end

endmodule

// File: sim/processor_tb.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module processor_tb;

	localparam int clock_period = 20;
	localparam int max_tests    = 5;
	localparam int prog_words   = 16;
	localparam int max_events   = 8;
	localparam int clear_words  = 128;
	localparam int row_cycles   = prog_words + 60;
	// Initial reset, imem clear, then every row
	localparam int watchdog_cycles = 3 + clear_words + max_tests * row_cycles;

	// One trace event, register number or store address in where
	typedef struct packed {
		logic               is_store;
		logic [`MEM_AW-1:0] where;
		logic [`XLEN-1:0]   value;
	} trace_t;

	logic               clock;
	logic               rst_n;
	logic               run;
	logic               prog_we;
	logic [`MEM_AW-1:0] prog_addr;
	logic [`XLEN-1:0]   prog_data;
	logic               wb_we;
	cpu_pkg::reg_idx_t  wb_reg;
	logic [`XLEN-1:0]   wb_data;
	logic               debug_we;
	logic [`MEM_AW-1:0] debug_addr;
	logic [`XLEN-1:0]   debug_data;

	// Test table
	string            test_name [max_tests];
	logic [`XLEN-1:0] test_prog [max_tests][prog_words];
	trace_t           test_trace [max_tests][max_events];
	int               exp_count [max_tests];
	int               num_loaded;
	int               cur;
	int               fill;

	processor uut (
		.clock(clock), .rst_n(rst_n), .run(run), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .wb_we(wb_we), .wb_reg(wb_reg),
		.wb_data(wb_data), .debug_we(debug_we), .debug_addr(debug_addr),
		.debug_data(debug_data)
	);

	bind processor processor_checker chk (
		.clock(clock), .rst_n(rst_n), .wb_we(wb_we), .wb_reg(wb_reg), .debug_we(debug_we)
	);

	initial clock = 1'b0;
	always #(clock_period / 2) clock = ~clock;

	//////////////////////////////
	// Encoding and table helpers
	//////////////////////////////

	function automatic logic [31:0] rtype_word(input cpu_pkg::alu_op_e op, input int rd,
		input int rs, input int rt, input int sh);
		return {cpu_pkg::op_rtype, 5'(rd), 5'(rs), 5'(rt), 5'(sh), op, 2'b00};
	endfunction

	function automatic logic [31:0] imm_word(input cpu_pkg::opcode_e op, input int rd,
		input int rs, input int imm);
		return {op, 5'(rd), 5'(rs), 17'(imm)};
	endfunction

	function automatic logic [31:0] jump_word(input cpu_pkg::opcode_e op, input int target);
		return {op, 27'(target)};
	endfunction

	task automatic begin_test(input string name);
		cur = num_loaded;
		num_loaded++;
		fill = 0;
		test_name[cur] = name;
		exp_count[cur] = 0;
		// Unused slots stay nops
		for (int i = 0; i < prog_words; i++)
			test_prog[cur][i] = '0;
	endtask

	task automatic emit(input logic [31:0] word);
		test_prog[cur][fill] = word;
		fill++;
	endtask

	task automatic expect_reg(input int r, input logic [31:0] value);
		test_trace[cur][exp_count[cur]] = '{is_store: 1'b0, where: `MEM_AW'(r), value: value};
		exp_count[cur]++;
	endtask

	task automatic expect_store(input int addr, input logic [31:0] value);
		test_trace[cur][exp_count[cur]] = '{is_store: 1'b1, where: `MEM_AW'(addr), value: value};
		exp_count[cur]++;
	endtask

	task automatic build_table();
		num_loaded = 0;

		// Back to back dependent ALU ops
		begin_test("alu");
		emit(imm_word(cpu_pkg::op_addi, 1, 0, 5));
		emit(imm_word(cpu_pkg::op_addi, 2, 1, -3));
		emit(rtype_word(cpu_pkg::alu_add, 3, 1, 2, 0));
		emit(rtype_word(cpu_pkg::alu_sub, 4, 2, 3, 0));
		emit(rtype_word(cpu_pkg::alu_and, 5, 4, 1, 0));
		emit(rtype_word(cpu_pkg::alu_or, 6, 5, 4, 0));
		emit(rtype_word(cpu_pkg::alu_sll, 7, 1, 0, 4));
		emit(rtype_word(cpu_pkg::alu_sra, 8, 4, 0, 1));
		expect_reg(1, 32'h0000_0005);
		expect_reg(2, 32'h0000_0002);
		expect_reg(3, 32'h0000_0007);
		expect_reg(4, 32'hffff_fffb);
		expect_reg(5, 32'h0000_0001);
		expect_reg(6, 32'hffff_fffb);
		expect_reg(7, 32'h0000_0050);
		expect_reg(8, 32'hffff_fffd);

		begin_test("reg_zero");
		emit(imm_word(cpu_pkg::op_addi, 0, 0, 7));
		emit(imm_word(cpu_pkg::op_addi, 1, 0, 3));
		emit(rtype_word(cpu_pkg::alu_add, 2, 0, 1, 0));
		emit(imm_word(cpu_pkg::op_addi, 0, 0, 9));
		emit(rtype_word(cpu_pkg::alu_add, 3, 0, 0, 0));
		expect_reg(1, 32'h0000_0003);
		expect_reg(2, 32'h0000_0003);
		expect_reg(3, 32'h0000_0000);

		// Store then load, nop before the use of the load
		begin_test("load_store");
		emit(imm_word(cpu_pkg::op_addi, 1, 0, 'h40));
		emit(imm_word(cpu_pkg::op_addi, 2, 0, 'h123));
		emit(imm_word(cpu_pkg::op_sw, 2, 1, 4));
		emit(imm_word(cpu_pkg::op_lw, 3, 1, 4));
		emit('0);
		emit(rtype_word(cpu_pkg::alu_add, 4, 3, 3, 0));
		emit(imm_word(cpu_pkg::op_addi, 5, 0, 'h77));
		emit(imm_word(cpu_pkg::op_sw, 5, 1, 0));
		expect_reg(1, 32'h0000_0040);
		expect_reg(2, 32'h0000_0123);
		expect_store('h44, 32'h0000_0123);
		expect_reg(3, 32'h0000_0123);
		expect_reg(4, 32'h0000_0246);
		expect_reg(5, 32'h0000_0077);
		expect_store('h40, 32'h0000_0077);

		// Markers in r9 must never show up
		begin_test("branch");
		emit(imm_word(cpu_pkg::op_addi, 1, 0, 3));
		emit(imm_word(cpu_pkg::op_bne, 1, 0, 1));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h99));
		emit(imm_word(cpu_pkg::op_addi, 2, 0, 1));
		emit(imm_word(cpu_pkg::op_bne, 2, 2, 1));
		emit(imm_word(cpu_pkg::op_addi, 3, 0, 'h33));
		emit(imm_word(cpu_pkg::op_addi, 4, 0, -2));
		emit(imm_word(cpu_pkg::op_blt, 4, 2, 1));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h98));
		emit(imm_word(cpu_pkg::op_addi, 5, 0, 7));
		emit(imm_word(cpu_pkg::op_blt, 5, 2, 1));
		emit(imm_word(cpu_pkg::op_addi, 6, 0, 'h66));
		expect_reg(1, 32'h0000_0003);
		expect_reg(2, 32'h0000_0001);
		expect_reg(3, 32'h0000_0033);
		expect_reg(4, 32'hffff_fffe);
		expect_reg(5, 32'h0000_0007);
		expect_reg(6, 32'h0000_0066);

		// jal at 4 links to 5, the routine at 8 returns through r31
		begin_test("jump");
		emit(imm_word(cpu_pkg::op_addi, 1, 0, 1));
		emit(jump_word(cpu_pkg::op_j, 4));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h99));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h98));
		emit(jump_word(cpu_pkg::op_jal, 8));
		emit(imm_word(cpu_pkg::op_addi, 2, 0, 'h22));
		emit(jump_word(cpu_pkg::op_j, 11));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h97));
		emit(imm_word(cpu_pkg::op_addi, 3, 0, 'h33));
		emit(imm_word(cpu_pkg::op_jr, 31, 0, 0));
		emit(imm_word(cpu_pkg::op_addi, 9, 0, 'h96));
		emit(imm_word(cpu_pkg::op_addi, 4, 0, 'h44));
		expect_reg(1, 32'h0000_0001);
		expect_reg(31, 32'h0000_0005);
		expect_reg(3, 32'h0000_0033);
		expect_reg(2, 32'h0000_0022);
		expect_reg(4, 32'h0000_0044);
	endtask

	//////////////////////////////
	// Checking
	//////////////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic take_event(input int t, input trace_t seen, inout int got, inout int extra);
		trace_t want;
		string  tag;
		if (got >= exp_count[t]) begin
			extra++;
		end else begin
			want = test_trace[t][got];
			tag = $sformatf("%s event %0d", test_name[t], got);
			check_value({tag, " kind"}, 32'(want.is_store), 32'(seen.is_store));
			check_value({tag, " target"}, 32'(want.where), 32'(seen.where));
			check_value({tag, " data"}, want.value, seen.value);
			got++;
		end
	endtask

	// Writeback belongs to the older instruction, so it goes first
	task automatic sample_events(input int t, inout int got, inout int extra);
		if (wb_we)
			take_event(t, '{is_store: 1'b0, where: `MEM_AW'(wb_reg), value: wb_data}, got, extra);
		if (debug_we)
			take_event(t, '{is_store: 1'b1, where: debug_addr, value: debug_data}, got, extra);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic write_imem(input int addr, input logic [31:0] word);
		prog_we = 1'b1;
		prog_addr = `MEM_AW'(addr);
		prog_data = word;
		@(posedge clock);
		#2;
		prog_we = 1'b0;
	endtask

	task automatic run_test(input int t);
		int got;
		int extra;
		got = 0;
		extra = 0;
		for (int i = 0; i < prog_words; i++)
			write_imem(i, test_prog[t][i]);

		rst_n = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;
		run = 1'b1;

		while (got < exp_count[t]) begin
			@(negedge clock);
			sample_events(t, got, extra);
		end
		// Pipeline must stay quiet afterwards
		repeat (20) begin
			@(negedge clock);
			sample_events(t, got, extra);
		end
		check_value({test_name[t], " extra events"}, 32'd0, 32'(extra));

		@(posedge clock);
		#2;
		run = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		build_table();
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;

		// Fill imem with nops past the end of every program
		for (int i = 0; i < clear_words; i++)
			write_imem(i, '0);

		for (int t = 0; t < num_loaded; t++)
			run_test(t);

		if (uut.chk.fail_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", uut.chk.fail_count);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	// Watchdog
	initial begin
		#(watchdog_cycles * clock_period);
		$display("Timeout, the run did not finish within %0d cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

endmodule

// File: list.f
+incdir+common
common/cpu_pkg.sv
verilog/stage_latch.sv
verilog/sync_ram.sv
verilog/regfile.sv
verilog/alu.sv
verilog/decoder.sv
verilog/bypass_unit.sv
verilog/processor.sv
sim/processor_checker.sv
sim/processor_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module processor_tb -Mdir obj_dir
	./obj_dir/Vprocessor_tb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
